/* tb.f */
+incdir+rtl
rtl/core_pkg.sv
rtl/instr_fetch.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/core_top.sv
testbench/tb_core.sv

/* Bender.yml */
package:
  name: mini_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/core_pkg.sv
      - rtl/instr_fetch.sv
      - rtl/register_file.sv
      - rtl/decode_stage.sv
      - rtl/execute_stage.sv
      - rtl/core_top.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - testbench/tb_core.sv

/* testbench/tb_core.sv */
/*
 * Testbench for the three-stage core
 * Instruction memory responder, reference model, write-back monitor
 * and the directed tests
 */
`timescale 1ns/1ps
`include "core_defines.svh"

module tb_core;

  localparam int RESET_CYCLES = 10;
  localparam int TAIL_CYCLES  = 10;
  localparam int NUM_TESTS    = 6;
  localparam int TOTAL_INSTR  = 95;
  localparam int CYCLE_LIMIT  = 8 * TOTAL_INSTR
                              + NUM_TESTS * (RESET_CYCLES + 4 + 2 * TAIL_CYCLES);
  // Fetch, decode and write-back registers
  localparam int PIPE_EDGES   = 3;

  logic                  clk;
  logic                  rst;
  logic                  imem_req;
  logic [`CORE_XLEN-1:0] imem_addr;
  logic                  imem_ack;
  logic [`CORE_XLEN-1:0] imem_rdata;
  logic                  wb_valid;
  logic [4:0]            wb_rd;
  logic [`CORE_XLEN-1:0] wb_data;

  logic [31:0] prog [0:63];
  bit          writes [0:63];
  int          prog_len;
  logic [31:0] model_regs [`CORE_NREGS];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  int          captures [$];
  int          max_delay;
  int          value_errors;
  int          other_errors;
  int          cycle_count;
  int          fetch_index;
  int          resp_delay;
  logic [31:0] resp_addr;
  logic [4:0]  mon_rd;
  logic [31:0] mon_data;
  int          mon_edge;
  int unsigned first_draw;

  core_top uut (
    .clk        (clk),
    .rst        (rst),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_ack   (imem_ack),
    .imem_rdata (imem_rdata),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
    cycle_count <= cycle_count + 1;

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, `CORE_OP_REG};
  endfunction

  function automatic logic [31:0] encode_i(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, `CORE_OP_IMM};
  endfunction

  // Past the program end the memory returns an unknown opcode
  function automatic logic [31:0] program_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - `CORE_RESET_PC) >> 2;
    if (idx < prog_len)
      return prog[idx];
    return {addr[31:7] ^ addr[24:0], 7'h7f};
  endfunction

  // Reference model, one instruction at a time
  task automatic add_instr(input logic [31:0] word);
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    bit          ok;
    rd     = word[11:7];
    f3     = word[14:12];
    a      = model_regs[word[19:15]];
    result = '0;
    ok     = 1'b1;
    if (word[6:0] == `CORE_OP_REG)
    begin
      b = model_regs[word[24:20]];
      if (word[31:25] == 7'h20 && f3 == 3'b000)
        result = a - b;
      else if (word[31:25] != 7'h00)
        ok = 1'b0;
      else if (f3 == 3'b000)
        result = a + b;
      else if (f3 == 3'b111)
        result = a & b;
      else if (f3 == 3'b110)
        result = a | b;
      else if (f3 == 3'b100)
        result = a ^ b;
      else
        ok = 1'b0;
    end
    else if (word[6:0] == `CORE_OP_IMM)
    begin
      b = {{20{word[31]}}, word[31:20]};
      case (f3)
        3'b000:  result = a + b;
        3'b111:  result = a & b;
        3'b110:  result = a | b;
        3'b100:  result = a ^ b;
        3'b010:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default: ok = 1'b0;
      endcase
    end
    else
      ok = 1'b0;
    prog[prog_len]   = word;
    writes[prog_len] = ok && (rd != 5'd0);
    if (writes[prog_len])
    begin
      model_regs[rd] = result;
      exp_rd.push_back(rd);
      exp_data.push_back(result);
    end
    prog_len++;
  endtask

  // Instruction memory, four-phase with a random delay before ack
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (rst)
        fetch_index = 0;
      else if (imem_req && !imem_ack)
      begin
        resp_addr = imem_addr;
        assert (resp_addr == `CORE_RESET_PC + 32'(4 * fetch_index))
        else
        begin
          $display("error: imem_addr got %h, expected %h", resp_addr,
                   `CORE_RESET_PC + 32'(4 * fetch_index));
          value_errors++;
        end
        resp_delay = $urandom_range(max_delay, 0);
        repeat (resp_delay) @(negedge clk);
        @(posedge clk);
        imem_rdata <= program_word(resp_addr);
        imem_ack   <= 1'b1;
        @(negedge clk);
        // Next edge is the capture edge
        if (imem_req && !rst)
        begin
          if (fetch_index < prog_len && writes[fetch_index])
            captures.push_back(cycle_count + 1);
          fetch_index++;
        end
        while (imem_req)
          @(negedge clk);
        @(posedge clk);
        imem_ack <= 1'b0;
      end
    end
  end

  // Write-back monitor
  always @(negedge clk)
  begin
    if (!rst && wb_valid)
    begin
      assert (exp_rd.size() > 0)
      else
      begin
        $display("unexpected register write to x%0d", wb_rd);
        other_errors++;
      end
      if (exp_rd.size() > 0)
      begin
        mon_rd   = exp_rd.pop_front();
        mon_data = exp_data.pop_front();
        assert (wb_rd == mon_rd)
        else
        begin
          $display("error: wb_rd got %h, expected %h", wb_rd, mon_rd);
          value_errors++;
        end
        assert (wb_data == mon_data)
        else
        begin
          $display("error: wb_data got %h, expected %h", wb_data, mon_data);
          value_errors++;
        end
        if (captures.size() > 0)
        begin
          mon_edge = captures.pop_front();
          // The capture edge loads the fetch register, the first of the three
          assert (cycle_count - mon_edge == PIPE_EDGES - 1)
          else
          begin
            $display("write to x%0d retired %0d edges after capture, expected %0d",
                     wb_rd, cycle_count - mon_edge + 1, PIPE_EDGES);
            other_errors++;
          end
        end
      end
    end
  end

  task automatic start_program();
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    prog_len = 0;
    exp_rd.delete();
    exp_data.delete();
    captures.delete();
    for (int r = 0; r < `CORE_NREGS; r++)
      model_regs[r] = '0;
  endtask

  task automatic execute_program();
    int waited;
    waited = 0;
    // One reset cycle already passed in start_program
    repeat (RESET_CYCLES - 1)
    begin
      @(negedge clk);
      assert (!imem_req && !wb_valid)
      else
      begin
        $display("imem_req or wb_valid went high during reset");
        other_errors++;
      end
    end
    @(posedge clk);
    rst <= 1'b0;
    while (exp_rd.size() > 0 && waited < 8 * prog_len + TAIL_CYCLES)
    begin
      @(negedge clk);
      waited++;
    end
    assert (exp_rd.size() == 0)
    else
    begin
      $display("%0d expected register writes never retired", exp_rd.size());
      other_errors++;
    end
    // Room for stray writes after the last expected one
    repeat (TAIL_CYCLES) @(negedge clk);
  endtask

  // Address order is checked by the memory on every request
  task automatic reset_and_fetch_order();
    start_program();
    max_delay = 3;
    add_instr(encode_i(3'b000, 5'd1, 5'd0, 12'd5));
    add_instr(encode_i(3'b000, 5'd2, 5'd1, 12'd7));
    add_instr(encode_i(3'b000, 5'd3, 5'd2, 12'hfff));
    execute_program();
  endtask

  task automatic r_format_alu();
    start_program();
    max_delay = 3;
    add_instr(encode_i(3'b000, 5'd1, 5'd0, 12'h123));
    add_instr(encode_i(3'b000, 5'd2, 5'd0, 12'hfaa));
    add_instr(encode_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    add_instr(encode_r(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
    add_instr(encode_r(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
    add_instr(encode_r(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
    add_instr(encode_r(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
    add_instr(encode_r(7'h20, 3'b000, 5'd8, 5'd2, 5'd1));
    execute_program();
  endtask

  // Negative immediates and signed compares
  task automatic i_format_alu();
    start_program();
    max_delay = 3;
    add_instr(encode_i(3'b000, 5'd1, 5'd0, 12'hfff));
    add_instr(encode_i(3'b000, 5'd2, 5'd1, 12'h800));
    add_instr(encode_i(3'b111, 5'd3, 5'd1, 12'hff0));
    add_instr(encode_i(3'b110, 5'd4, 5'd0, 12'hf00));
    add_instr(encode_i(3'b100, 5'd5, 5'd2, 12'hfff));
    add_instr(encode_i(3'b010, 5'd6, 5'd2, 12'hffb));
    add_instr(encode_i(3'b010, 5'd7, 5'd1, 12'hfff));
    add_instr(encode_i(3'b010, 5'd8, 5'd0, 12'hfff));
    add_instr(encode_i(3'b010, 5'd9, 5'd2, 12'h7ff));
    execute_program();
  endtask

  // Fastest spacing, each result is read by the next instruction
  task automatic dependency_chain();
    start_program();
    max_delay = 0;
    add_instr(encode_i(3'b000, 5'd1, 5'd0, 12'd1));
    add_instr(encode_r(7'h00, 3'b000, 5'd2, 5'd1, 5'd1));
    add_instr(encode_i(3'b100, 5'd3, 5'd2, 12'h055));
    add_instr(encode_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd2));
    add_instr(encode_r(7'h00, 3'b110, 5'd5, 5'd4, 5'd3));
    add_instr(encode_i(3'b010, 5'd6, 5'd5, 12'd0));
    add_instr(encode_i(3'b000, 5'd6, 5'd6, 12'd100));
    execute_program();
  endtask

  task automatic bubble_handling();
    start_program();
    max_delay = 2;
    add_instr(encode_i(3'b000, 5'd1, 5'd0, 12'd9));
    add_instr(32'hffff_ffff);
    add_instr(32'h0000_0000);
    add_instr(encode_i(3'b000, 5'd0, 5'd1, 12'd7));
    add_instr(encode_r(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
    add_instr(encode_r(7'h01, 3'b000, 5'd2, 5'd1, 5'd1));
    // x0 must still read as zero
    add_instr(encode_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd0));
    add_instr(encode_r(7'h00, 3'b110, 5'd4, 5'd0, 5'd0));
    execute_program();
  endtask

  task automatic random_program();
    int          op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    start_program();
    max_delay = 3;
    for (int n = 0; n < 60; n++)
    begin
      op  = $urandom_range(9, 0);
      // Few registers, so results are read again soon
      rd  = 5'($urandom_range(7, 0));
      rs1 = 5'($urandom_range(7, 0));
      rs2 = 5'($urandom_range(7, 0));
      imm = 12'($urandom);
      case (op)
        0:       add_instr(encode_r(7'h00, 3'b000, rd, rs1, rs2));
        1:       add_instr(encode_r(7'h20, 3'b000, rd, rs1, rs2));
        2:       add_instr(encode_r(7'h00, 3'b111, rd, rs1, rs2));
        3:       add_instr(encode_r(7'h00, 3'b110, rd, rs1, rs2));
        4:       add_instr(encode_r(7'h00, 3'b100, rd, rs1, rs2));
        5:       add_instr(encode_i(3'b000, rd, rs1, imm));
        6:       add_instr(encode_i(3'b111, rd, rs1, imm));
        7:       add_instr(encode_i(3'b110, rd, rs1, imm));
        8:       add_instr(encode_i(3'b100, rd, rs1, imm));
        default: add_instr(encode_i(3'b010, rd, rs1, imm));
      endcase
    end
    execute_program();
  endtask

  initial
  begin
    wait (cycle_count >= CYCLE_LIMIT);
    $display("timeout after %0d cycles", cycle_count);
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    rst          = 1'b1;
    imem_ack     = 1'b0;
    imem_rdata   = '0;
    max_delay    = 0;
    prog_len     = 0;
    value_errors = 0;
    other_errors = 0;
    cycle_count  = 0;
    fetch_index  = 0;
    first_draw   = $urandom(32'h0ded_e2ea);
    reset_and_fetch_order();
    r_format_alu();
    i_format_alu();
    dependency_chain();
    bubble_handling();
    random_program();
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* rtl/core_top.sv */
/*
 * Core top level
 * Fetch, decode and execute stages with instruction port and retire trace
 */
`timescale 1ns/1ps
`include "core_defines.svh"

module core_top (
  input  logic                  clk,
  input  logic                  rst,
  output logic                  imem_req,
  output logic [`CORE_XLEN-1:0] imem_addr,
  input  logic                  imem_ack,
  input  logic [`CORE_XLEN-1:0] imem_rdata,
  output logic                  wb_valid,
  output logic [4:0]            wb_rd,
  output logic [`CORE_XLEN-1:0] wb_data
);

  // Fetch to decode
  logic                  f_valid;
  core_pkg::instr_u      f_instr;

  // Decode to execute
  logic                  d_valid;
  logic [4:0]            d_rd;
  core_pkg::alu_op_e     d_alu_op;
  logic [`CORE_XLEN-1:0] d_op_a;
  logic [`CORE_XLEN-1:0] d_op_b;

  instr_fetch u_fetch (
    .clk        (clk),
    .rst        (rst),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_ack   (imem_ack),
    .imem_rdata (imem_rdata),
    .f_valid    (f_valid),
    .f_instr    (f_instr)
  );

  // Write-back loops back into the register file inside decode
  decode_stage u_decode (
    .clk      (clk),
    .rst      (rst),
    .f_valid  (f_valid),
    .f_instr  (f_instr),
    .wb_we    (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .d_valid  (d_valid),
    .d_rd     (d_rd),
    .d_alu_op (d_alu_op),
    .d_op_a   (d_op_a),
    .d_op_b   (d_op_b)
  );

  execute_stage u_execute (
    .clk      (clk),
    .rst      (rst),
    .d_valid  (d_valid),
    .d_rd     (d_rd),
    .d_alu_op (d_alu_op),
    .d_op_a   (d_op_a),
    .d_op_b   (d_op_b),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

endmodule

/* rtl/execute_stage.sv */
/*
 * Execute stage
 * ALU and the write-back register feeding the register file
 */
`timescale 1ns/1ps
`include "core_defines.svh"

module execute_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  d_valid,
  input  logic [4:0]            d_rd,
  input  core_pkg::alu_op_e     d_alu_op,
  input  logic [`CORE_XLEN-1:0] d_op_a,
  input  logic [`CORE_XLEN-1:0] d_op_b,
  output logic                  wb_valid,
  output logic [4:0]            wb_rd,
  output logic [`CORE_XLEN-1:0] wb_data
);

  logic [`CORE_XLEN-1:0] alu_result;

  always_comb
  begin
    case (d_alu_op)
      core_pkg::ALU_ADD: alu_result = d_op_a + d_op_b;
      core_pkg::ALU_SUB: alu_result = d_op_a - d_op_b;
      core_pkg::ALU_AND: alu_result = d_op_a & d_op_b;
      core_pkg::ALU_OR:  alu_result = d_op_a | d_op_b;
      core_pkg::ALU_XOR: alu_result = d_op_a ^ d_op_b;
      // Signed compare, result is 0 or 1
      core_pkg::ALU_SLT:
        alu_result = ($signed(d_op_a) < $signed(d_op_b)) ? `CORE_XLEN'd1 : '0;
      default:           alu_result = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      wb_valid <= 1'b0;
    else
      wb_valid <= d_valid;
  end

  // Also the register file write port and the retire trace
  always_ff @(posedge clk)
  begin
    if (d_valid)
    begin
      wb_rd   <= d_rd;
      wb_data <= alu_result;
    end
  end

endmodule

/* rtl/decode_stage.sv */
/*
 * Decode stage
 * Opcode and function decoding, operand read and decode register
 */
`timescale 1ns/1ps
`include "core_defines.svh"

module decode_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  f_valid,
  input  core_pkg::instr_u      f_instr,
  input  logic                  wb_we,
  input  logic [4:0]            wb_rd,
  input  logic [`CORE_XLEN-1:0] wb_data,
  output logic                  d_valid,
  output logic [4:0]            d_rd,
  output core_pkg::alu_op_e     d_alu_op,
  output logic [`CORE_XLEN-1:0] d_op_a,
  output logic [`CORE_XLEN-1:0] d_op_b
);

  logic [`CORE_XLEN-1:0] rdata_a;
  logic [`CORE_XLEN-1:0] rdata_b;
  logic                  dec_ok;
  logic [4:0]            dec_rd;
  core_pkg::alu_op_e     dec_op;
  logic [`CORE_XLEN-1:0] dec_op_b;

  // rs1 and rs2 sit at the same bits in both layouts
  register_file u_regfile (
    .clk     (clk),
    .rst     (rst),
    .we      (wb_we),
    .waddr   (wb_rd),
    .wdata   (wb_data),
    .raddr_a (f_instr.r.rs1),
    .raddr_b (f_instr.r.rs2),
    .rdata_a (rdata_a),
    .rdata_b (rdata_b)
  );

  always_comb
  begin
    dec_ok   = 1'b0;
    dec_rd   = f_instr.r.rd;
    dec_op   = core_pkg::ALU_ADD;
    dec_op_b = rdata_b;
    case (f_instr.r.opcode)
      `CORE_OP_REG:
      begin
        dec_ok = 1'b1;
        case ({f_instr.r.funct7, f_instr.r.funct3})
          {7'b0000000, 3'b000}: dec_op = core_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: dec_op = core_pkg::ALU_SUB;
          {7'b0000000, 3'b111}: dec_op = core_pkg::ALU_AND;
          {7'b0000000, 3'b110}: dec_op = core_pkg::ALU_OR;
          {7'b0000000, 3'b100}: dec_op = core_pkg::ALU_XOR;
          default:              dec_ok = 1'b0;
        endcase
      end
      `CORE_OP_IMM:
      begin
        dec_ok   = 1'b1;
        // Sign-extended 12-bit immediate
        dec_op_b = {{(`CORE_XLEN-12){f_instr.i.imm[11]}}, f_instr.i.imm};
        case (f_instr.i.funct3)
          3'b000:  dec_op = core_pkg::ALU_ADD;
          3'b111:  dec_op = core_pkg::ALU_AND;
          3'b110:  dec_op = core_pkg::ALU_OR;
          3'b100:  dec_op = core_pkg::ALU_XOR;
          3'b010:  dec_op = core_pkg::ALU_SLT;
          default: dec_ok = 1'b0;
        endcase
      end
      default: dec_ok = 1'b0;
    endcase
  end

  // Unknown encodings and writes to x0 leave as bubbles
  always_ff @(posedge clk)
  begin
    if (rst)
      d_valid <= 1'b0;
    else
      d_valid <= f_valid && dec_ok && (dec_rd != 5'd0);
  end

  always_ff @(posedge clk)
  begin
    if (f_valid)
    begin
      d_rd     <= dec_rd;
      d_alu_op <= dec_op;
      d_op_a   <= rdata_a;
      d_op_b   <= dec_op_b;
    end
  end

endmodule

/* rtl/register_file.sv */
/*
 * Integer register file
 * Two read ports, one write port, x0 fixed at zero, write-through reads
 */
`timescale 1ns/1ps
`include "core_defines.svh"

module register_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  we,
  input  logic [4:0]            waddr,
  input  logic [`CORE_XLEN-1:0] wdata,
  input  logic [4:0]            raddr_a,
  input  logic [4:0]            raddr_b,
  output logic [`CORE_XLEN-1:0] rdata_a,
  output logic [`CORE_XLEN-1:0] rdata_b
);

  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < `CORE_NREGS; i++)
        regs[i] <= '0;
    end
    else if (we && waddr != 5'd0)
      regs[waddr] <= wdata;
  end

  // Same-cycle write is forwarded, so decode never sees a stale value
  assign rdata_a = (raddr_a == 5'd0)              ? '0    :
                   (we && waddr == raddr_a)       ? wdata : regs[raddr_a];
  assign rdata_b = (raddr_b == 5'd0)              ? '0    :
                   (we && waddr == raddr_b)       ? wdata : regs[raddr_b];

endmodule

/* rtl/instr_fetch.sv */
/*
 * Fetch stage
 * PC, four-phase req/ack instruction port and fetch register
 */
`timescale 1ns/1ps
`include "core_defines.svh"

module instr_fetch (
  input  logic                  clk,
  input  logic                  rst,
  output logic                  imem_req,
  output logic [`CORE_XLEN-1:0] imem_addr,
  input  logic                  imem_ack,
  input  logic [`CORE_XLEN-1:0] imem_rdata,
  output logic                  f_valid,
  output core_pkg::instr_u      f_instr
);

  // Handshake states
  localparam logic [1:0] S_IDLE     = 2'd0;
  localparam logic [1:0] S_REQ      = 2'd1;
  localparam logic [1:0] S_WAIT_LOW = 2'd2;

  logic [1:0]            state;
  logic [`CORE_XLEN-1:0] pc;

  // Address is held stable for the whole request phase
  assign imem_addr = pc;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= S_IDLE;
      imem_req <= 1'b0;
      f_valid  <= 1'b0;
      pc       <= `CORE_RESET_PC;
    end
    else
    begin
      f_valid <= 1'b0;
      case (state)
        S_IDLE:
        begin
          imem_req <= 1'b1;
          state    <= S_REQ;
        end
        S_REQ:
        begin
          // Word is valid together with ack
          if (imem_ack)
          begin
            f_valid  <= 1'b1;
            imem_req <= 1'b0;
            pc       <= pc + `CORE_XLEN'd4;
            state    <= S_WAIT_LOW;
          end
        end
        S_WAIT_LOW:
        begin
          // Memory must release ack before the next request
          if (!imem_ack)
          begin
            imem_req <= 1'b1;
            state    <= S_REQ;
          end
        end
        default:
        begin
          imem_req <= 1'b0;
          state    <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == S_REQ && imem_ack)
      f_instr <= imem_rdata;
  end

endmodule

/* rtl/core_pkg.sv */
/*
 * Shared core types
 * R-format and I-format instruction views, the instruction union
 * and the ALU operation encoding
 */
package core_pkg;

  // Register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // Register-immediate layout
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // One fetched word, seen through either layout
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } alu_op_e;

endpackage

/* rtl/core_defines.svh */
/*
 * Core-wide parameters
 * Data width, register count, reset PC and ALU opcodes
 */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Word width for data and instructions
`define CORE_XLEN 32

// Architectural registers, x0 included
`define CORE_NREGS 32

// First fetch address, advances by 4 per word
`define CORE_RESET_PC 32'h0000_0000

// Major opcodes of the two ALU classes
`define CORE_OP_REG 7'b0110011
`define CORE_OP_IMM 7'b0010011

`endif
